// File: build.f
+incdir+testbench
design/md5_pkg.sv
design/md5_constant_rom.sv
design/md5_message_buffer.sv
design/md5_round_functions.sv
design/md5_chunk_cruncher.sv
design/md5_core.sv
testbench/tb_md5_core.sv

// File: run.sh
#!/bin/sh
# build and run the md5_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f build.f --top-module tb_md5_core -o tb_md5_core; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_md5_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: testbench/md5_ref_model.svh
`ifndef MD5_REF_MODEL_SVH
`define MD5_REF_MODEL_SVH

// additive constants, floor(abs(sin(i+1)) * 2^32)
localparam logic [31:0] k_table [64] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
};

// rotate amounts, four per quarter
localparam int s_table [16] = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};

logic [7:0] msg_bytes [$];
logic [7:0] pad_bytes [$];

// 0x80, zero fill to 56 mod 64, then the bit length little endian
function automatic void pad_message();
    logic [63:0] bit_len;
    bit_len = 64'(msg_bytes.size()) * 64'd8;
    pad_bytes = msg_bytes;
    pad_bytes.push_back(8'h80);
    while (pad_bytes.size() % 64 != 56) begin
        pad_bytes.push_back(8'h00);
    end
    for (int i = 0; i < 8; i++) begin
        pad_bytes.push_back(bit_len[8*i +: 8]);
    end
endfunction

// word j of the chunk sits in bits 32j and up, little endian bytes
function automatic logic [511:0] chunk_of(input int n);
    logic [511:0] chunk;
    for (int j = 0; j < 64; j++) begin
        chunk[8*j +: 8] = pad_bytes[64*n + j];
    end
    return chunk;
endfunction

function automatic logic [31:0] rotate_left(input logic [31:0] x, input int n);
    return (x << n) | (x >> (32 - n));
endfunction

// state is {d, c, b, a}, same word order as the DUT digest
function automatic logic [127:0] compress_chunk(input logic [127:0] state,
                                                input logic [511:0] chunk);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] f;
    logic [31:0] tmp;
    int          g;
    a = state[31:0];
    b = state[63:32];
    c = state[95:64];
    d = state[127:96];
    for (int i = 0; i < 64; i++) begin
        if (i < 16) begin
            f = (b & c) | (~b & d);
            g = i;
        end else if (i < 32) begin
            f = (d & b) | (~d & c);
            g = (5 * i + 1) % 16;
        end else if (i < 48) begin
            f = b ^ c ^ d;
            g = (3 * i + 5) % 16;
        end else begin
            f = c ^ (b | ~d);
            g = (7 * i) % 16;
        end
        tmp = d;
        d   = c;
        c   = b;
        b   = b + rotate_left(a + f + k_table[i] + chunk[32*g +: 32],
                              s_table[(i / 16) * 4 + i % 4]);
        a   = tmp;
    end
    return {state[127:96] + d, state[95:64] + c, state[63:32] + b, state[31:0] + a};
endfunction

// printed digest byte order, a0 lowest byte first
function automatic logic [127:0] byte_order(input logic [127:0] dg);
    logic [127:0] out;
    for (int i = 0; i < 16; i++) begin
        out[8*(15-i) +: 8] = dg[8*i +: 8];
    end
    return out;
endfunction

`endif

// File: testbench/tb_md5_core.sv
`timescale 1ns/100ps

module tb_md5_core;

    localparam int total_chunks = 38;
    localparam int watchdog_cycles = total_chunks * 300 + 2000;
    localparam int done_limit = 400;

    logic         clk;
    logic         reset;
    logic         word_write;
    logic [3:0]   word_index;
    logic [31:0]  word_data;
    logic         start;
    logic         done;
    logic [127:0] digest;

    int           errors;
    int           checks;
    logic [31:0]  rng_state;
    logic [127:0] model_state;
    int           latency_cycles;
    logic         done_dropped;

    `include "md5_ref_model.svh"

    md5_core u_md5_core (
        .clk        (clk),
        .reset      (reset),
        .word_write (word_write),
        .word_index (word_index),
        .word_data  (word_data),
        .start      (start),
        .done       (done),
        .digest     (digest)
    );

    // stage name for the waveform viewer
    md5_pkg::md5_stage_t stage_view;
    assign stage_view = u_md5_core.u_chunk_cruncher.stage;

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_equal(input logic [127:0] got, input logic [127:0] expected,
                               input string what);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("Error at %0d ns: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset      <= 1'b1;
        start      <= 1'b0;
        word_write <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        model_state = {md5_pkg::MD5_INIT_D, md5_pkg::MD5_INIT_C,
                       md5_pkg::MD5_INIT_B, md5_pkg::MD5_INIT_A};
    endtask

    task automatic load_and_start(input logic [511:0] chunk);
        for (int j = 0; j < 16; j++) begin
            @(posedge clk);
            word_write <= 1'b1;
            word_index <= 4'(j);
            word_data  <= chunk[32*j +: 32];
        end
        @(posedge clk);
        word_write <= 1'b0;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // counts edges after the start edge, sampled on the falling edge
    task automatic wait_for_done();
        latency_cycles = 0;
        @(negedge clk);
        done_dropped = !done;
        while (!done && latency_cycles < done_limit) begin
            @(negedge clk);
            latency_cycles++;
        end
        checks++;
        assert (done) else begin
            errors++;
            $display("done did not come back within %0d cycles of start", done_limit);
        end
    endtask

    task automatic hash_message(input string what);
        logic [511:0] chunk;
        pad_message();
        for (int n = 0; n < pad_bytes.size() / 64; n++) begin
            chunk = chunk_of(n);
            model_state = compress_chunk(model_state, chunk);
            load_and_start(chunk);
            wait_for_done();
            check_equal(digest, model_state, $sformatf("%s chunk %0d", what, n));
        end
    endtask

    task automatic fill_random(input int len);
        logic [31:0] rnd;
        msg_bytes.delete();
        for (int i = 0; i < len; i++) begin
            rnd = next_random();
            msg_bytes.push_back(rnd[7:0]);
        end
    endtask

    task automatic reset_state_check();
        apply_reset();
        @(negedge clk);
        check_equal(128'(done), 128'd1, "done after reset");
        check_equal(digest, model_state, "digest after reset");
    endtask

    task automatic empty_message_vector();
        apply_reset();
        msg_bytes.delete();
        hash_message("empty message");
        check_equal(byte_order(digest), 128'hd41d8cd98f00b204e9800998ecf8427e, "empty digest");
    endtask

    task automatic abc_vector();
        apply_reset();
        msg_bytes.delete();
        msg_bytes.push_back(8'h61);
        msg_bytes.push_back(8'h62);
        msg_bytes.push_back(8'h63);
        hash_message("abc");
        check_equal(byte_order(digest), 128'h900150983cd24fb0d6963f7d28e17f72, "abc digest");
    endtask

    task automatic random_single_chunks();
        logic [31:0] rnd;
        for (int t = 0; t < 20; t++) begin
            apply_reset();
            rnd = next_random();
            fill_random(int'(rnd % 32'd56));
            hash_message($sformatf("single chunk message %0d", t));
        end
    endtask

    // chunks of one message go back to back, the chaining value carries over
    task automatic random_multi_chunks();
        logic [31:0] rnd;
        for (int t = 0; t < 6; t++) begin
            apply_reset();
            rnd = next_random();
            if (t < 3) begin
                fill_random(56 + int'(rnd % 32'd64));
            end else begin
                fill_random(120 + int'(rnd % 32'd64));
            end
            hash_message($sformatf("multi chunk message %0d", t));
        end
    endtask

    task automatic latency_check();
        apply_reset();
        fill_random(20);
        hash_message("latency message");
        check_equal(128'(done_dropped), 128'd1, "done low after start");
        check_equal(128'(latency_cycles), 128'd260, "cycles from start to done");
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        errors     = 0;
        checks     = 0;
        rng_state  = 32'hd953;
        reset      <= 1'b1;
        word_write <= 1'b0;
        word_index <= 4'd0;
        word_data  <= 32'd0;
        start      <= 1'b0;

        reset_state_check();
        empty_message_vector();
        abc_vector();
        random_single_chunks();
        random_multi_chunks();
        latency_check();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: design/md5_core.sv
`timescale 1ns/100ps

module md5_core (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       word_write,
    input  logic [3:0]                 word_index,
    input  logic [md5_pkg::WORD_W-1:0] word_data,
    input  logic                       start,
    output logic                       done,
    output logic [127:0]               digest
);

    logic [md5_pkg::ROUND_W-1:0] round_index;
    logic [md5_pkg::WORD_W-1:0]  k_word;
    logic [4:0]                  s_amount;
    logic [md5_pkg::WORD_W-1:0]  f_value;
    logic [3:0]                  message_index;
    logic [md5_pkg::WORD_W-1:0]  m_word;
    logic [md5_pkg::WORD_W-1:0]  b;
    logic [md5_pkg::WORD_W-1:0]  c;
    logic [md5_pkg::WORD_W-1:0]  d;

    md5_message_buffer u_message_buffer (
        .clk           (clk),
        .word_write    (word_write),
        .word_index    (word_index),
        .word_data     (word_data),
        .message_index (message_index),
        .m_word        (m_word)
    );

    md5_constant_rom u_constant_rom (
        .clk         (clk),
        .round_index (round_index),
        .k_word      (k_word),
        .s_amount    (s_amount)
    );

    md5_round_functions u_round_functions (
        .round_index   (round_index),
        .b             (b),
        .c             (c),
        .d             (d),
        .f_value       (f_value),
        .message_index (message_index)
    );

    // chaining value starts from the standard IV
    md5_chunk_cruncher #(
        .init_a (md5_pkg::MD5_INIT_A),
        .init_b (md5_pkg::MD5_INIT_B),
        .init_c (md5_pkg::MD5_INIT_C),
        .init_d (md5_pkg::MD5_INIT_D)
    ) u_chunk_cruncher (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .done        (done),
        .digest      (digest),
        .round_index (round_index),
        .k_word      (k_word),
        .s_amount    (s_amount),
        .f_value     (f_value),
        .m_word      (m_word),
        .b           (b),
        .c           (c),
        .d           (d)
    );

endmodule

// File: design/md5_chunk_cruncher.sv
`timescale 1ns/100ps

module md5_chunk_cruncher #(
    parameter logic [md5_pkg::WORD_W-1:0] init_a = md5_pkg::MD5_INIT_A,
    parameter logic [md5_pkg::WORD_W-1:0] init_b = md5_pkg::MD5_INIT_B,
    parameter logic [md5_pkg::WORD_W-1:0] init_c = md5_pkg::MD5_INIT_C,
    parameter logic [md5_pkg::WORD_W-1:0] init_d = md5_pkg::MD5_INIT_D
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    output logic                        done,
    output logic [127:0]                digest,
    output logic [md5_pkg::ROUND_W-1:0] round_index,
    input  logic [md5_pkg::WORD_W-1:0]  k_word,
    input  logic [4:0]                  s_amount,
    input  logic [md5_pkg::WORD_W-1:0]  f_value,
    input  logic [md5_pkg::WORD_W-1:0]  m_word,
    output logic [md5_pkg::WORD_W-1:0]  b,
    output logic [md5_pkg::WORD_W-1:0]  c,
    output logic [md5_pkg::WORD_W-1:0]  d
);

    // chaining value
    logic [md5_pkg::WORD_W-1:0] a0;
    logic [md5_pkg::WORD_W-1:0] b0;
    logic [md5_pkg::WORD_W-1:0] c0;
    logic [md5_pkg::WORD_W-1:0] d0;

    logic [md5_pkg::WORD_W-1:0] a;
    logic [md5_pkg::WORD_W-1:0] t0;
    logic [md5_pkg::WORD_W-1:0] t1;

    md5_pkg::md5_stage_t         stage;
    logic [1:0]                  step;
    logic [md5_pkg::ROUND_W-1:0] round_q;

    logic [md5_pkg::WORD_W-1:0]   add_x;
    logic [md5_pkg::WORD_W-1:0]   add_y;
    logic [md5_pkg::WORD_W-1:0]   sum;
    logic [2*md5_pkg::WORD_W-1:0] rot_wide;
    logic [md5_pkg::WORD_W-1:0]   rotated;

    assign digest = {d0, c0, b0, a0};
    assign done   = (stage == md5_pkg::finished);

    // a restart must present round 0 to the registered lookups on the start edge
    assign round_index = start ? '0 : round_q;

    // left rotate, upper half of the doubled word
    assign rot_wide = {t0, t0} << s_amount;
    assign rotated  = rot_wide[2*md5_pkg::WORD_W-1:md5_pkg::WORD_W];

    // operand select for the one shared adder
    always_comb begin
        add_x = '0;
        add_y = '0;
        if (stage == md5_pkg::crunch) begin
            case (step)
                2'd0: begin
                    add_x = a;
                    add_y = k_word;
                end
                2'd1: begin
                    add_x = f_value;
                    add_y = m_word;
                end
                2'd2: begin
                    add_x = t0;
                    add_y = t1;
                end
                2'd3: begin
                    add_x = b;
                    add_y = rotated;
                end
            endcase
        end else if (stage == md5_pkg::finalize) begin
            case (step)
                2'd0: begin
                    add_x = a0;
                    add_y = a;
                end
                2'd1: begin
                    add_x = b0;
                    add_y = b;
                end
                2'd2: begin
                    add_x = c0;
                    add_y = c;
                end
                2'd3: begin
                    add_x = d0;
                    add_y = d;
                end
            endcase
        end
    end

    assign sum = add_x + add_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            a0      <= init_a;
            b0      <= init_b;
            c0      <= init_c;
            d0      <= init_d;
            round_q <= '0;
            step    <= 2'd0;
            stage   <= md5_pkg::finished;
        end else if (start) begin
            round_q <= '0;
            step    <= 2'd0;
            stage   <= md5_pkg::crunch;
        end else if (stage == md5_pkg::crunch) begin
            step <= step + 2'd1;
            if (step == 2'd2) begin
                round_q <= round_q + 1'b1;
            end
            // index has wrapped after round 63
            if (step == 2'd3 && round_q == '0) begin
                stage <= md5_pkg::finalize;
            end
        end else if (stage == md5_pkg::finalize) begin
            step <= step + 2'd1;
            case (step)
                2'd0: a0 <= sum;
                2'd1: b0 <= sum;
                2'd2: c0 <= sum;
                2'd3: begin
                    d0    <= sum;
                    stage <= md5_pkg::finished;
                end
            endcase
        end
    end

    // working registers and temporaries
    always_ff @(posedge clk) begin
        if (start) begin
            a <= a0;
            b <= b0;
            c <= c0;
            d <= d0;
        end else if (stage == md5_pkg::crunch) begin
            case (step)
                2'd0: t0 <= sum;
                2'd1: t1 <= sum;
                2'd2: t0 <= sum;
                2'd3: begin
                    a <= d;
                    b <= sum;
                    c <= b;
                    d <= c;
                end
            endcase
        end
    end

endmodule

// File: design/md5_round_functions.sv
`timescale 1ns/100ps

module md5_round_functions (
    input  logic [md5_pkg::ROUND_W-1:0] round_index,
    input  logic [md5_pkg::WORD_W-1:0]  b,
    input  logic [md5_pkg::WORD_W-1:0]  c,
    input  logic [md5_pkg::WORD_W-1:0]  d,
    output logic [md5_pkg::WORD_W-1:0]  f_value,
    output logic [3:0]                  message_index
);

    logic [3:0] r;

    assign r = round_index[3:0];

    always_comb begin
        case (round_index[5:4])
            // F and i
            2'd0: begin
                f_value       = (b & c) | (~b & d);
                message_index = r;
            end
            // G and 5i+1
            2'd1: begin
                f_value       = (d & b) | (~d & c);
                message_index = {r[1:0], 2'b00} + r + 4'd1;
            end
            // H and 3i+5
            2'd2: begin
                f_value       = b ^ c ^ d;
                message_index = {r[2:0], 1'b0} + r + 4'd5;
            end
            // I and 7i, taken as 8i-i
            2'd3: begin
                f_value       = c ^ (b | ~d);
                message_index = {r[0], 3'b000} - r;
            end
        endcase
    end

endmodule

// File: design/md5_message_buffer.sv
`timescale 1ns/100ps

module md5_message_buffer (
    input  logic                       clk,
    input  logic                       word_write,
    input  logic [3:0]                 word_index,
    input  logic [md5_pkg::WORD_W-1:0] word_data,
    input  logic [3:0]                 message_index,
    output logic [md5_pkg::WORD_W-1:0] m_word
);

    // sixteen words of the current chunk
    logic [md5_pkg::WORD_W-1:0] mem [16];

    always_ff @(posedge clk) begin
        if (word_write) begin
            mem[word_index] <= word_data;
        end
    end

    // read is registered so it lines up with the constant ROM
    always_ff @(posedge clk) begin
        m_word <= mem[message_index];
    end

endmodule

// File: design/md5_constant_rom.sv
`timescale 1ns/100ps

module md5_constant_rom (
    input  logic                        clk,
    input  logic [md5_pkg::ROUND_W-1:0] round_index,
    output logic [md5_pkg::WORD_W-1:0]  k_word,
    output logic [4:0]                  s_amount
);

    logic [md5_pkg::WORD_W-1:0] k_next;
    logic [19:0]                s_row;
    logic [4:0]                 s_next;

    // sine-derived additive constants
    always_comb begin
        case (round_index)
            6'd0:  k_next = 32'hd76aa478;
            6'd1:  k_next = 32'he8c7b756;
            6'd2:  k_next = 32'h242070db;
            6'd3:  k_next = 32'hc1bdceee;
            6'd4:  k_next = 32'hf57c0faf;
            6'd5:  k_next = 32'h4787c62a;
            6'd6:  k_next = 32'ha8304613;
            6'd7:  k_next = 32'hfd469501;
            6'd8:  k_next = 32'h698098d8;
            6'd9:  k_next = 32'h8b44f7af;
            6'd10: k_next = 32'hffff5bb1;
            6'd11: k_next = 32'h895cd7be;
            6'd12: k_next = 32'h6b901122;
            6'd13: k_next = 32'hfd987193;
            6'd14: k_next = 32'ha679438e;
            6'd15: k_next = 32'h49b40821;
            6'd16: k_next = 32'hf61e2562;
            6'd17: k_next = 32'hc040b340;
            6'd18: k_next = 32'h265e5a51;
            6'd19: k_next = 32'he9b6c7aa;
            6'd20: k_next = 32'hd62f105d;
            6'd21: k_next = 32'h02441453;
            6'd22: k_next = 32'hd8a1e681;
            6'd23: k_next = 32'he7d3fbc8;
            6'd24: k_next = 32'h21e1cde6;
            6'd25: k_next = 32'hc33707d6;
            6'd26: k_next = 32'hf4d50d87;
            6'd27: k_next = 32'h455a14ed;
            6'd28: k_next = 32'ha9e3e905;
            6'd29: k_next = 32'hfcefa3f8;
            6'd30: k_next = 32'h676f02d9;
            6'd31: k_next = 32'h8d2a4c8a;
            6'd32: k_next = 32'hfffa3942;
            6'd33: k_next = 32'h8771f681;
            6'd34: k_next = 32'h6d9d6122;
            6'd35: k_next = 32'hfde5380c;
            6'd36: k_next = 32'ha4beea44;
            6'd37: k_next = 32'h4bdecfa9;
            6'd38: k_next = 32'hf6bb4b60;
            6'd39: k_next = 32'hbebfbc70;
            6'd40: k_next = 32'h289b7ec6;
            6'd41: k_next = 32'heaa127fa;
            6'd42: k_next = 32'hd4ef3085;
            6'd43: k_next = 32'h04881d05;
            6'd44: k_next = 32'hd9d4d039;
            6'd45: k_next = 32'he6db99e5;
            6'd46: k_next = 32'h1fa27cf8;
            6'd47: k_next = 32'hc4ac5665;
            6'd48: k_next = 32'hf4292244;
            6'd49: k_next = 32'h432aff97;
            6'd50: k_next = 32'hab9423a7;
            6'd51: k_next = 32'hfc93a039;
            6'd52: k_next = 32'h655b59c3;
            6'd53: k_next = 32'h8f0ccc92;
            6'd54: k_next = 32'hffeff47d;
            6'd55: k_next = 32'h85845dd1;
            6'd56: k_next = 32'h6fa87e4f;
            6'd57: k_next = 32'hfe2ce6e0;
            6'd58: k_next = 32'ha3014314;
            6'd59: k_next = 32'h4e0811a1;
            6'd60: k_next = 32'hf7537e82;
            6'd61: k_next = 32'hbd3af235;
            6'd62: k_next = 32'h2ad7d2bb;
            6'd63: k_next = 32'heb86d391;
        endcase
    end

    // rotate amounts repeat every four rounds within a quarter,
    // packed with the first round of the group in the low bits
    always_comb begin
        case (round_index[5:4])
            2'd0: s_row = {5'd22, 5'd17, 5'd12, 5'd7};
            2'd1: s_row = {5'd20, 5'd14, 5'd9, 5'd5};
            2'd2: s_row = {5'd23, 5'd16, 5'd11, 5'd4};
            2'd3: s_row = {5'd21, 5'd15, 5'd10, 5'd6};
        endcase
        s_next = s_row[round_index[1:0]*5 +: 5];
    end

    always_ff @(posedge clk) begin
        k_word   <= k_next;
        s_amount <= s_next;
    end

endmodule

// File: design/md5_pkg.sv
package md5_pkg;

    // datapath widths
    localparam int WORD_W  = 32;
    localparam int ROUND_W = 6;

    // standard MD5 initial chaining words
    localparam logic [WORD_W-1:0] MD5_INIT_A = 32'h67452301;
    localparam logic [WORD_W-1:0] MD5_INIT_B = 32'hefcdab89;
    localparam logic [WORD_W-1:0] MD5_INIT_C = 32'h98badcfe;
    localparam logic [WORD_W-1:0] MD5_INIT_D = 32'h10325476;

    // cruncher stage
    // crunch runs the 64 rounds, finalize folds the working registers
    // into the chaining value, finished is the idle stage
    typedef enum logic [1:0] {
        crunch   = 2'd0,
        finalize = 2'd1,
        finished = 2'd2
    } md5_stage_t;

endpackage
